// File: vlog.f
+incdir+testbench
design/cfg_pkg.sv
design/cfg_write_ctrl.sv
design/cfg_reg64.sv
design/cfg_read_mux.sv
design/dma_cfg_top.sv
testbench/dma_cfg_assert.sv
testbench/tb_dma_cfg.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the DMA config testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
   -f vlog.f \
   --top-module tb_dma_cfg \
   -o tb_dma_cfg

./obj_dir/tb_dma_cfg | tee "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
   echo "simulation reported failures, see $LOG"
   exit 1
fi

echo "simulation finished without failures"

// File: testbench/tb_dma_cfg_model.svh
// --------------------------------------
// reference model of the config registers
// byte-masked 64-bit slots plus four flags,
// included into the testbench module body
// --------------------------------------
`ifndef TB_DMA_CFG_MODEL_SVH
`define TB_DMA_CFG_MODEL_SVH

// word index of each 64-bit slot, in ring_cfg order
logic [5:0]  slot_word [15] = '{6'd1, 6'd5, 6'd7, 6'd9, 6'd13, 6'd15, 6'd16, 6'd17,
                                6'd18, 6'd19, 6'd41, 6'd42, 6'd43, 6'd45, 6'd46};
// tx int enable, rx int enable, soft reset, pkt ready
logic [5:0]  flag_word [4] = '{6'd25, 6'd26, 6'd30, 6'd44};
logic [63:0] m_reg [15];
// bit 3 is flag_word[0], same order as the flags struct
logic [3:0]  m_flags;

function automatic int find_slot(input logic [5:0] idx);
   int slot;
   slot = -1;
   for (int i = 0; i < 15; i++) begin
      if (slot_word[i] == idx) begin
         slot = i;
      end
   end
   return slot;
endfunction

function automatic int find_flag(input logic [5:0] idx);
   int flag;
   flag = -1;
   for (int i = 0; i < 4; i++) begin
      if (flag_word[i] == idx) begin
         flag = i;
      end
   end
   return flag;
endfunction

// a ring of N 64-byte units is masked by N*64-1
function automatic logic [63:0] ring_mask(input int units);
   return 64'(units * 64 - 1);
endfunction

task automatic model_reset();
   m_reg[0] = ring_mask(cfg_pkg::MEM_N_TX_DSC);
   m_reg[1] = ring_mask(cfg_pkg::MEM_N_TX_PKT);
   m_reg[2] = ring_mask(cfg_pkg::MEM_N_TX_DNE);
   m_reg[3] = ring_mask(cfg_pkg::MEM_N_RX_DSC);
   m_reg[4] = ring_mask(cfg_pkg::MEM_N_RX_PKT);
   m_reg[5] = ring_mask(cfg_pkg::MEM_N_RX_DNE);
   for (int i = 6; i < 15; i++) begin
      m_reg[i] = 64'd0;
   end
   // interrupts on, soft reset and pkt ready clear
   m_flags = 4'b1100;
endtask

function automatic logic [31:0] model_read_lo(input logic [5:0] idx);
   int slot;
   int flag;
   slot = find_slot(idx);
   flag = find_flag(idx);
   if (slot >= 0) begin
      return m_reg[slot][31:0];
   end else if (flag >= 0) begin
      return {31'd0, m_flags[3 - flag]};
   end
   return 32'd0;
endfunction

// flags and holes read as zero on the hi lane
function automatic logic [31:0] model_read_hi(input logic [5:0] idx);
   int slot;
   slot = find_slot(idx);
   if (slot >= 0) begin
      return m_reg[slot][63:32];
   end
   return 32'd0;
endfunction

task automatic model_write(input logic valid, input cfg_pkg::cfg_wr_lane_t lo,
                           input cfg_pkg::cfg_wr_lane_t hi);
   int slot_lo;
   int slot_hi;
   int flag;
   slot_lo = find_slot(lo.addr[8:3]);
   slot_hi = find_slot(hi.addr[8:3]);
   flag = find_flag(lo.addr[8:3]);
   for (int b = 0; b < 4; b++) begin
      if (valid && lo.en && slot_lo >= 0 && lo.mask[b]) begin
         m_reg[slot_lo][b*8 +: 8] = lo.data[b*8 +: 8];
      end
      if (valid && hi.en && slot_hi >= 0 && hi.mask[b]) begin
         m_reg[slot_hi][32 + b*8 +: 8] = hi.data[b*8 +: 8];
      end
   end
   // only the lo lane reaches a flag
   if (valid && lo.en && flag >= 0 && lo.mask[0]) begin
      m_flags[3 - flag] = lo.data[0];
   end
endtask

`endif

// File: testbench/tb_dma_cfg.sv
// --------------------------------------
// testbench for the DMA config block
// random lane traffic, checked cycle by
// cycle against the register model
// --------------------------------------
`timescale 1ns/100ps

module tb_dma_cfg;

   logic                  pcie_clk;
   logic                  rst;
   logic                  wr_mem_valid;
   logic                  rd_mem_valid;
   cfg_pkg::cfg_wr_lane_t wr_lo;
   cfg_pkg::cfg_wr_lane_t wr_hi;
   cfg_pkg::cfg_rd_lane_t rd_lo;
   cfg_pkg::cfg_rd_lane_t rd_hi;
   logic [31:0]           rd_data_lo;
   logic [31:0]           rd_data_hi;
   cfg_pkg::ring_cfg_t    ring_cfg;
   cfg_pkg::cfg_flags_t   flags;

   integer      seed;
   int          errors;
   int          checks;
   int          tests_run;
   int          tests_failed;
   int          test_start_errors;
   logic [31:0] exp_lo;
   logic [31:0] exp_hi;

   `include "tb_dma_cfg_model.svh"

   dma_cfg_top u_dut (
      .pcie_clk     (pcie_clk),
      .rst          (rst),
      .wr_mem_valid (wr_mem_valid),
      .rd_mem_valid (rd_mem_valid),
      .wr_lo        (wr_lo),
      .wr_hi        (wr_hi),
      .rd_lo        (rd_lo),
      .rd_hi        (rd_hi),
      .rd_data_lo   (rd_data_lo),
      .rd_data_hi   (rd_data_hi),
      .ring_cfg     (ring_cfg),
      .flags        (flags)
   );

   initial begin
      pcie_clk = 1'b0;
      forever #2 pcie_clk = ~pcie_clk;
   end

   // --------------------------------------
   // stimulus helpers
   // --------------------------------------
   function automatic logic [31:0] rnd();
      return $random(seed);
   endfunction

   function automatic int rnd_below(input int n);
      logic [31:0] r;
      r = rnd();
      return int'(r % 32'(n));
   endfunction

   // index 0 and 32 are both holes in the map
   function automatic logic [5:0] hole_idx();
      logic [31:0] r;
      logic [5:0]  idx;
      r = rnd();
      idx = r[5:0];
      if (find_slot(idx) >= 0 || find_flag(idx) >= 0) begin
         idx = {r[6], 5'd0};
      end
      return idx;
   endfunction

   // mostly registers, some flags, a few holes
   function automatic logic [5:0] pick_idx();
      int r;
      r = rnd_below(16);
      if (r < 11) begin
         return slot_word[rnd_below(15)];
      end else if (r < 14) begin
         return flag_word[rnd_below(4)];
      end
      return hole_idx();
   endfunction

   // bits outside 8:3 carry no index
   function automatic logic [11:0] make_addr(input logic [5:0] idx);
      logic [31:0] r;
      r = rnd();
      return {r[11:9], idx, r[2:0]};
   endfunction

   function automatic cfg_pkg::cfg_wr_lane_t wr_lane(input logic en, input logic [5:0] idx,
                                                     input logic [31:0] data,
                                                     input logic [3:0] mask);
      cfg_pkg::cfg_wr_lane_t lane;
      lane.en   = en;
      lane.addr = make_addr(idx);
      lane.data = data;
      lane.mask = mask;
      return lane;
   endfunction

   function automatic cfg_pkg::cfg_rd_lane_t rd_lane(input logic en, input logic [5:0] idx);
      cfg_pkg::cfg_rd_lane_t lane;
      lane.en   = en;
      lane.addr = make_addr(idx);
      return lane;
   endfunction

   task automatic drive_idle();
      wr_mem_valid = 1'b0;
      rd_mem_valid = 1'b0;
      wr_lo = '0;
      wr_hi = '0;
      rd_lo = '0;
      rd_hi = '0;
   endtask

   // --------------------------------------
   // checking
   // --------------------------------------
   task automatic report_mismatch(input string what, input logic [63:0] got,
                                  input logic [63:0] want);
      errors++;
      $display("FAILED at %0t: %0s is %h, expected %h", $time, what, got, want);
   endtask

   task automatic check_outputs();
      logic [959:0] ring_bits;
      ring_bits = ring_cfg;
      checks++;
      assert (rd_data_lo === exp_lo)
         else report_mismatch("rd_data_lo", {32'd0, rd_data_lo}, {32'd0, exp_lo});
      assert (rd_data_hi === exp_hi)
         else report_mismatch("rd_data_hi", {32'd0, rd_data_hi}, {32'd0, exp_hi});
      // first struct field sits at the top
      for (int i = 0; i < 15; i++) begin
         assert (ring_bits[(14 - i) * 64 +: 64] === m_reg[i])
            else report_mismatch($sformatf("ring_cfg slot %0d", i),
                                 ring_bits[(14 - i) * 64 +: 64], m_reg[i]);
      end
      assert (flags === m_flags)
         else report_mismatch("flags", {60'd0, flags}, {60'd0, m_flags});
   endtask

   // reads see the state from before this edge's write
   task automatic cycle_and_check();
      if (rd_mem_valid && rd_lo.en) begin
         exp_lo = model_read_lo(rd_lo.addr[8:3]);
      end
      if (rd_mem_valid && rd_hi.en) begin
         exp_hi = model_read_hi(rd_hi.addr[8:3]);
      end
      model_write(wr_mem_valid, wr_lo, wr_hi);
      @(posedge pcie_clk);
      #1;
      check_outputs();
   endtask

   task automatic read_back(input logic [5:0] idx_lo, input logic [5:0] idx_hi);
      drive_idle();
      rd_mem_valid = 1'b1;
      rd_lo = rd_lane(1'b1, idx_lo);
      rd_hi = rd_lane(1'b1, idx_hi);
      cycle_and_check();
   endtask

   task automatic start_test();
      test_start_errors = errors;
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors != test_start_errors) begin
         tests_failed++;
      end
      $display("test %0s: %0d errors", name, errors - test_start_errors);
   endtask

   // --------------------------------------
   // tests
   // --------------------------------------
   task automatic test_reset_values();
      start_test();
      for (int i = 0; i < 15; i++) begin
         read_back(slot_word[i], slot_word[i]);
      end
      for (int i = 0; i < 4; i++) begin
         read_back(flag_word[i], flag_word[i]);
      end
      finish_test("reset values");
   endtask

   task automatic test_full_writes();
      logic [5:0]  idx;
      logic [31:0] d_lo;
      logic [31:0] d_hi;
      start_test();
      repeat (30) begin
         idx = slot_word[rnd_below(15)];
         d_lo = rnd();
         d_hi = rnd();
         wr_mem_valid = 1'b1;
         wr_lo = wr_lane(1'b1, idx, d_lo, 4'hf);
         wr_hi = wr_lane(1'b1, idx, d_hi, 4'hf);
         cycle_and_check();
         read_back(idx, idx);
         assert ({rd_data_hi, rd_data_lo} === {d_hi, d_lo})
            else report_mismatch("full write readback", {rd_data_hi, rd_data_lo}, {d_hi, d_lo});
      end
      finish_test("full writes");
   endtask

   task automatic test_byte_masks();
      logic [5:0]  idx_a;
      logic [5:0]  idx_b;
      logic [31:0] r;
      start_test();
      repeat (40) begin
         idx_a = slot_word[rnd_below(15)];
         idx_b = slot_word[rnd_below(15)];
         r = rnd();
         wr_mem_valid = 1'b1;
         wr_lo = wr_lane(1'b1, idx_a, rnd(), r[3:0]);
         wr_hi = wr_lane(1'b1, idx_b, rnd(), r[7:4]);
         cycle_and_check();
         read_back(idx_a, idx_b);
      end
      finish_test("byte masks");
   endtask

   task automatic test_flag_writes();
      logic [5:0]  f_lo;
      logic [5:0]  f_hi;
      logic [31:0] r;
      start_test();
      repeat (40) begin
         f_lo = flag_word[rnd_below(4)];
         f_hi = flag_word[rnd_below(4)];
         r = rnd();
         wr_mem_valid = 1'b1;
         wr_lo = wr_lane(r[0] | r[1], f_lo, rnd(), r[7:4]);
         wr_hi = wr_lane(1'b1, f_hi, rnd(), 4'hf);
         cycle_and_check();
         read_back(f_lo, f_hi);
         assert (rd_data_hi === 32'd0)
            else report_mismatch("hi read of a flag", {32'd0, rd_data_hi}, 64'd0);
      end
      finish_test("flag writes");
   endtask

   task automatic test_unmapped_and_gating();
      int         mode;
      logic [5:0] idx_w;
      start_test();
      repeat (40) begin
         // mode 0 writes holes, 1 drops valid, 2 drops the lane enables
         mode = rnd_below(3);
         idx_w = (mode == 0) ? hole_idx() : slot_word[rnd_below(15)];
         wr_mem_valid = (mode != 1);
         wr_lo = wr_lane(mode != 2, idx_w, rnd(), 4'hf);
         wr_hi = wr_lane(mode != 2, idx_w, rnd(), 4'hf);
         cycle_and_check();
         read_back(hole_idx(), hole_idx());
         assert ({rd_data_hi, rd_data_lo} === 64'd0)
            else report_mismatch("unmapped read", {rd_data_hi, rd_data_lo}, 64'd0);
      end
      finish_test("unmapped and gating");
   endtask

   task automatic test_random_mix();
      logic [5:0]  w_lo;
      logic [5:0]  w_hi;
      logic [5:0]  r_lo;
      logic [5:0]  r_hi;
      logic [31:0] r;
      start_test();
      repeat (400) begin
         w_lo = pick_idx();
         w_hi = pick_idx();
         r_lo = pick_idx();
         r_hi = pick_idx();
         r = rnd();
         // about one cycle in four reads what it writes
         if (r[1:0] == 2'd0) begin
            r_lo = w_lo;
            r_hi = w_hi;
         end
         wr_mem_valid = r[2] | r[3];
         rd_mem_valid = r[4] | r[5];
         wr_lo = wr_lane(r[6] | r[7], w_lo, rnd(), r[19:16]);
         wr_hi = wr_lane(r[8] | r[9], w_hi, rnd(), r[23:20]);
         rd_lo = rd_lane(r[10] | r[11], r_lo);
         rd_hi = rd_lane(r[12] | r[13], r_hi);
         cycle_and_check();
      end
      drive_idle();
      cycle_and_check();
      finish_test("random mix");
   endtask

   task automatic wait_reset_state(output logic settled);
      int n;
      n = 0;
      settled = 1'b0;
      while (!settled && n < 20) begin
         if (flags === 4'b1100 && rd_data_lo === 32'd0 && rd_data_hi === 32'd0) begin
            settled = 1'b1;
         end else begin
            @(posedge pcie_clk);
            #1;
            n++;
         end
      end
      if (!settled) begin
         errors++;
         $display("timeout: DUT outputs never reached their reset state");
      end
   endtask

   task automatic close_run();
      $display("summary: %0d tests, %0d failed, %0d cycles checked, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   endtask

   initial begin
      logic settled;
      seed = 32'h24e0_2092;
      errors = 0;
      checks = 0;
      tests_run = 0;
      tests_failed = 0;
      exp_lo = '0;
      exp_hi = '0;
      rst = 1'b1;
      drive_idle();
      model_reset();
      repeat (16) @(posedge pcie_clk);
      #1;
      rst = 1'b0;
      wait_reset_state(settled);
      if (settled) begin
         test_reset_values();
         test_full_writes();
         test_byte_masks();
         test_flag_writes();
         test_unmapped_and_gating();
         test_random_mix();
      end
      close_run();
   end

endmodule

// File: testbench/dma_cfg_assert.sv
// --------------------------------------
// concurrent checks on the config block,
// bound into every dma_cfg_top instance
// --------------------------------------
`timescale 1ns/100ps

module dma_cfg_assert (
   input logic                          pcie_clk,
   input logic                          rst,
   input logic                          wr_mem_valid,
   input logic                          rd_mem_valid,
   input cfg_pkg::cfg_wr_lane_t         wr_lo,
   input cfg_pkg::cfg_wr_lane_t         wr_hi,
   input cfg_pkg::cfg_rd_lane_t         rd_hi,
   input logic [cfg_pkg::DATA_BITS-1:0] rd_data_hi,
   input cfg_pkg::ring_cfg_t            ring_cfg,
   input cfg_pkg::cfg_flags_t           flags
);

   logic [cfg_pkg::CFG_IDX_BITS-1:0] rd_hi_idx;
   logic                             hi_flag_rd;
   logic                             any_wr;

   assign rd_hi_idx  = rd_hi.addr[cfg_pkg::CFG_ADDR_BITS-1:3];
   assign hi_flag_rd = rd_mem_valid && rd_hi.en &&
                       (rd_hi_idx == cfg_pkg::IDX_TX_INT_EN ||
                        rd_hi_idx == cfg_pkg::IDX_RX_INT_EN ||
                        rd_hi_idx == cfg_pkg::IDX_SOFT_RESET ||
                        rd_hi_idx == cfg_pkg::IDX_PKT_READY);
   assign any_wr     = wr_mem_valid && (wr_lo.en || wr_hi.en);

   // soft reset stays inactive coming out of reset
   soft_reset_clear: assert property (@(posedge pcie_clk) rst |=> !flags.soft_reset)
      else $error("soft_reset set in the cycle after reset");

   hi_flag_read_zero: assert property (@(posedge pcie_clk) disable iff (rst)
      hi_flag_rd |=> rd_data_hi == '0)
      else $error("hi lane read of a flag index returned nonzero data");

   ring_cfg_stable: assert property (@(posedge pcie_clk) disable iff (rst)
      !any_wr |=> ring_cfg == $past(ring_cfg))
      else $error("ring_cfg changed without a valid write");

endmodule

bind dma_cfg_top dma_cfg_assert u_assert (
   .pcie_clk     (pcie_clk),
   .rst          (rst),
   .wr_mem_valid (wr_mem_valid),
   .rd_mem_valid (rd_mem_valid),
   .wr_lo        (wr_lo),
   .wr_hi        (wr_hi),
   .rd_hi        (rd_hi),
   .rd_data_hi   (rd_data_hi),
   .ring_cfg     (ring_cfg),
   .flags        (flags)
);

// File: design/dma_cfg_top.sv
// --------------------------------------
// host config register block of the DMA
// engine, all on pcie_clk
// writes and reads complete in one cycle
// --------------------------------------
`timescale 1ns/100ps

module dma_cfg_top (
   input  logic                          pcie_clk,
   input  logic                          rst,
   input  logic                          wr_mem_valid,
   input  logic                          rd_mem_valid,
   input  cfg_pkg::cfg_wr_lane_t         wr_lo,
   input  cfg_pkg::cfg_wr_lane_t         wr_hi,
   input  cfg_pkg::cfg_rd_lane_t         rd_lo,
   input  cfg_pkg::cfg_rd_lane_t         rd_hi,
   output logic [cfg_pkg::DATA_BITS-1:0] rd_data_lo,
   output logic [cfg_pkg::DATA_BITS-1:0] rd_data_hi,
   output cfg_pkg::ring_cfg_t            ring_cfg,
   output cfg_pkg::cfg_flags_t           flags
);

   logic [cfg_pkg::N_REG64-1:0] sel_lo;
   logic [cfg_pkg::N_REG64-1:0] sel_hi;
   logic [63:0]                 reg_value [cfg_pkg::N_REG64];

   cfg_write_ctrl u_write_ctrl (
      .pcie_clk     (pcie_clk),
      .rst          (rst),
      .wr_mem_valid (wr_mem_valid),
      .wr_lo        (wr_lo),
      .wr_hi        (wr_hi),
      .sel_lo       (sel_lo),
      .sel_hi       (sel_hi),
      .flags        (flags)
   );

   // --------------------------------------
   // 64-bit register array
   // --------------------------------------
   for (genvar i = 0; i < cfg_pkg::N_REG64; i++) begin : g_reg
      cfg_reg64 #(
         .RESET_VALUE (cfg_pkg::REG_RESET[i])
      ) u_reg (
         .pcie_clk (pcie_clk),
         .rst      (rst),
         .sel_lo   (sel_lo[i]),
         .sel_hi   (sel_hi[i]),
         .wr_lo    (wr_lo),
         .wr_hi    (wr_hi),
         .value    (reg_value[i])
      );
   end

   cfg_read_mux u_read_mux (
      .pcie_clk     (pcie_clk),
      .rst          (rst),
      .rd_mem_valid (rd_mem_valid),
      .rd_lo        (rd_lo),
      .rd_hi        (rd_hi),
      .regs         (reg_value),
      .flags        (flags),
      .rd_data_lo   (rd_data_lo),
      .rd_data_hi   (rd_data_hi)
   );

   // slot order matches REG_IDX
   assign ring_cfg.tx_dsc_mask        = reg_value[0];
   assign ring_cfg.tx_pkt_mask        = reg_value[1];
   assign ring_cfg.tx_dne_mask        = reg_value[2];
   assign ring_cfg.rx_dsc_mask        = reg_value[3];
   assign ring_cfg.rx_pkt_mask        = reg_value[4];
   assign ring_cfg.rx_dne_mask        = reg_value[5];
   assign ring_cfg.host_tx_dne_offset = reg_value[6];
   assign ring_cfg.host_tx_dne_mask   = reg_value[7];
   assign ring_cfg.host_rx_dne_offset = reg_value[8];
   assign ring_cfg.host_rx_dne_mask   = reg_value[9];
   assign ring_cfg.host_rx_pkt_offset = reg_value[10];
   assign ring_cfg.host_rx_pkt_mask   = reg_value[11];
   assign ring_cfg.host_rx_pkt_head   = reg_value[12];
   assign ring_cfg.host_rx_dne_head   = reg_value[13];
   assign ring_cfg.mem_rx_pkt_head    = reg_value[14];

endmodule

// File: design/cfg_read_mux.sv
// --------------------------------------
// registered read data for the lo and hi
// read lanes, one cycle after the request
// output holds while a lane is idle
// --------------------------------------
`timescale 1ns/100ps

module cfg_read_mux (
   input  logic                          pcie_clk,
   input  logic                          rst,
   input  logic                          rd_mem_valid,
   input  cfg_pkg::cfg_rd_lane_t         rd_lo,
   input  cfg_pkg::cfg_rd_lane_t         rd_hi,
   input  logic [63:0]                   regs [cfg_pkg::N_REG64],
   input  cfg_pkg::cfg_flags_t           flags,
   output logic [cfg_pkg::DATA_BITS-1:0] rd_data_lo,
   output logic [cfg_pkg::DATA_BITS-1:0] rd_data_hi
);

   logic [cfg_pkg::CFG_IDX_BITS-1:0] idx_lo;
   logic [cfg_pkg::CFG_IDX_BITS-1:0] idx_hi;
   logic [cfg_pkg::DATA_BITS-1:0]    lo_next;
   logic [cfg_pkg::DATA_BITS-1:0]    hi_next;

   assign idx_lo = rd_lo.addr[cfg_pkg::CFG_ADDR_BITS-1:3];
   assign idx_hi = rd_hi.addr[cfg_pkg::CFG_ADDR_BITS-1:3];

   // --------------------------------------
   // selection
   // --------------------------------------
   // unmapped indices fall through as zero
   always_comb begin
      lo_next = '0;
      hi_next = '0;
      for (int i = 0; i < cfg_pkg::N_REG64; i++) begin
         if (idx_lo == cfg_pkg::REG_IDX[i]) begin
            lo_next = regs[i][cfg_pkg::DATA_BITS-1:0];
         end
         if (idx_hi == cfg_pkg::REG_IDX[i]) begin
            hi_next = regs[i][63:cfg_pkg::DATA_BITS];
         end
      end
      // flags read on the lo lane only, bit 0
      case (idx_lo)
         cfg_pkg::IDX_TX_INT_EN:  lo_next = {31'd0, flags.tx_int_enable};
         cfg_pkg::IDX_RX_INT_EN:  lo_next = {31'd0, flags.rx_int_enable};
         cfg_pkg::IDX_SOFT_RESET: lo_next = {31'd0, flags.soft_reset};
         cfg_pkg::IDX_PKT_READY:  lo_next = {31'd0, flags.host_rx_pkt_ready};
         default: ;
      endcase
   end

   // --------------------------------------
   // output registers
   // --------------------------------------
   always_ff @(posedge pcie_clk) begin
      if (rst) begin
         rd_data_lo <= '0;
         rd_data_hi <= '0;
      end else begin
         if (rd_mem_valid && rd_lo.en) begin
            rd_data_lo <= lo_next;
         end
         if (rd_mem_valid && rd_hi.en) begin
            rd_data_hi <= hi_next;
         end
      end
   end

endmodule

// File: design/cfg_reg64.sv
// --------------------------------------
// one 64-bit config register
// lo lane writes bytes 0-3, hi lane bytes 4-7
// --------------------------------------
`timescale 1ns/100ps

module cfg_reg64 #(
   parameter logic [63:0] RESET_VALUE = 64'd0
) (
   input  logic                  pcie_clk,
   input  logic                  rst,
   input  logic                  sel_lo,
   input  logic                  sel_hi,
   input  cfg_pkg::cfg_wr_lane_t wr_lo,
   input  cfg_pkg::cfg_wr_lane_t wr_hi,
   output logic [63:0]           value
);

   // byte lanes update independently, so a partial
   // write from either side leaves the rest alone
   always_ff @(posedge pcie_clk) begin
      if (rst) begin
         value <= RESET_VALUE;
      end else begin
         for (int b = 0; b < cfg_pkg::MASK_BITS; b++) begin
            if (sel_lo && wr_lo.mask[b]) begin
               value[b*8 +: 8] <= wr_lo.data[b*8 +: 8];
            end
            // upper word sits one lane width above
            if (sel_hi && wr_hi.mask[b]) begin
               value[cfg_pkg::DATA_BITS + b*8 +: 8] <= wr_hi.data[b*8 +: 8];
            end
         end
      end
   end

endmodule

// File: design/cfg_write_ctrl.sv
// --------------------------------------
// write decoder for the host config lanes
// turns each lane into a one-hot register
// strobe and holds the four flag bits
// --------------------------------------
`timescale 1ns/100ps

module cfg_write_ctrl (
   input  logic                         pcie_clk,
   input  logic                         rst,
   input  logic                         wr_mem_valid,
   input  cfg_pkg::cfg_wr_lane_t        wr_lo,
   input  cfg_pkg::cfg_wr_lane_t        wr_hi,
   output logic [cfg_pkg::N_REG64-1:0]  sel_lo,
   output logic [cfg_pkg::N_REG64-1:0]  sel_hi,
   output cfg_pkg::cfg_flags_t          flags
);

   logic [cfg_pkg::CFG_IDX_BITS-1:0] idx_lo;
   logic [cfg_pkg::CFG_IDX_BITS-1:0] idx_hi;
   logic                             wr_lo_go;
   logic                             wr_hi_go;
   logic                             flag_wr;

   assign idx_lo = wr_lo.addr[cfg_pkg::CFG_ADDR_BITS-1:3];
   assign idx_hi = wr_hi.addr[cfg_pkg::CFG_ADDR_BITS-1:3];

   assign wr_lo_go = wr_mem_valid && wr_lo.en;
   assign wr_hi_go = wr_mem_valid && wr_hi.en;

   // --------------------------------------
   // register strobes
   // --------------------------------------
   // at most one bit per lane, unmapped indices give none
   always_comb begin
      for (int i = 0; i < cfg_pkg::N_REG64; i++) begin
         sel_lo[i] = wr_lo_go && (idx_lo == cfg_pkg::REG_IDX[i]);
         sel_hi[i] = wr_hi_go && (idx_hi == cfg_pkg::REG_IDX[i]);
      end
   end

   // --------------------------------------
   // flag bits
   // --------------------------------------
   // flags only take the lo lane, gated by byte 0
   assign flag_wr = wr_lo_go && wr_lo.mask[0];

   always_ff @(posedge pcie_clk) begin
      if (rst) begin
         // interrupts come up enabled
         flags.tx_int_enable     <= 1'b1;
         flags.rx_int_enable     <= 1'b1;
         flags.soft_reset        <= 1'b0;
         flags.host_rx_pkt_ready <= 1'b0;
      end else if (flag_wr) begin
         case (idx_lo)
            cfg_pkg::IDX_TX_INT_EN:  flags.tx_int_enable     <= wr_lo.data[0];
            cfg_pkg::IDX_RX_INT_EN:  flags.rx_int_enable     <= wr_lo.data[0];
            cfg_pkg::IDX_SOFT_RESET: flags.soft_reset        <= wr_lo.data[0];
            cfg_pkg::IDX_PKT_READY:  flags.host_rx_pkt_ready <= wr_lo.data[0];
            default: ;
         endcase
      end
   end

endmodule

// File: design/cfg_pkg.sv
// --------------------------------------
// shared widths, register map, ring sizes
// and lane structs for the DMA config block
// referenced by scoped names from every module
// --------------------------------------

package cfg_pkg;

   // --------------------------------------
   // address and lane widths
   // --------------------------------------
   localparam int MEM_ADDR_BITS = 12;
   localparam int CFG_ADDR_BITS = 9;
   // word index is addr[CFG_ADDR_BITS-1:3]
   localparam int CFG_IDX_BITS  = 6;
   localparam int DATA_BITS     = 32;
   localparam int MASK_BITS     = 4;

   // --------------------------------------
   // register map
   // --------------------------------------
   localparam int N_REG64 = 15;

   // slot i answers at word index REG_IDX[i]
   localparam logic [CFG_IDX_BITS-1:0] REG_IDX [0:N_REG64-1] = '{
      6'd1,  6'd5,  6'd7,  6'd9,  6'd13,
      6'd15, 6'd16, 6'd17, 6'd18, 6'd19,
      6'd41, 6'd42, 6'd43, 6'd45, 6'd46
   };

   // single-bit flags, lo lane only
   localparam logic [CFG_IDX_BITS-1:0] IDX_TX_INT_EN  = 6'd25;
   localparam logic [CFG_IDX_BITS-1:0] IDX_RX_INT_EN  = 6'd26;
   localparam logic [CFG_IDX_BITS-1:0] IDX_SOFT_RESET = 6'd30;
   localparam logic [CFG_IDX_BITS-1:0] IDX_PKT_READY  = 6'd44;

   // ring sizes in 64 byte units
   localparam int MEM_N_TX_DSC = 4;
   localparam int MEM_N_TX_PKT = 8;
   localparam int MEM_N_TX_DNE = 4;
   localparam int MEM_N_RX_DSC = 4;
   localparam int MEM_N_RX_PKT = 8;
   localparam int MEM_N_RX_DNE = 4;

   // ring masks cover the whole ring, host pointers start at zero
   localparam logic [63:0] REG_RESET [0:N_REG64-1] = '{
      64'(MEM_N_TX_DSC * 64 - 1),
      64'(MEM_N_TX_PKT * 64 - 1),
      64'(MEM_N_TX_DNE * 64 - 1),
      64'(MEM_N_RX_DSC * 64 - 1),
      64'(MEM_N_RX_PKT * 64 - 1),
      64'(MEM_N_RX_DNE * 64 - 1),
      64'd0, 64'd0, 64'd0, 64'd0,
      64'd0, 64'd0, 64'd0, 64'd0, 64'd0
   };

   // --------------------------------------
   // lane and output structs
   // --------------------------------------
   typedef struct packed {
      logic                     en;
      logic [MEM_ADDR_BITS-1:0] addr;
      logic [DATA_BITS-1:0]     data;
      logic [MASK_BITS-1:0]     mask;
   } cfg_wr_lane_t;

   typedef struct packed {
      logic                     en;
      logic [MEM_ADDR_BITS-1:0] addr;
   } cfg_rd_lane_t;

   typedef struct packed {
      logic tx_int_enable;
      logic rx_int_enable;
      logic soft_reset;
      logic host_rx_pkt_ready;
   } cfg_flags_t;

   // field order follows REG_IDX
   typedef struct packed {
      logic [63:0] tx_dsc_mask;
      logic [63:0] tx_pkt_mask;
      logic [63:0] tx_dne_mask;
      logic [63:0] rx_dsc_mask;
      logic [63:0] rx_pkt_mask;
      logic [63:0] rx_dne_mask;
      logic [63:0] host_tx_dne_offset;
      logic [63:0] host_tx_dne_mask;
      logic [63:0] host_rx_dne_offset;
      logic [63:0] host_rx_dne_mask;
      logic [63:0] host_rx_pkt_offset;
      logic [63:0] host_rx_pkt_mask;
      logic [63:0] host_rx_pkt_head;
      logic [63:0] host_rx_dne_head;
      logic [63:0] mem_rx_pkt_head;
   } ring_cfg_t;

endpackage
